// ==== sources.f ====
+incdir+design
design/mbus_bridge_pkg.sv
design/mbus_clk_divider.sv
design/rx_serializer.sv
design/tx_assembler.sv
design/ack_builder.sv
design/bridge_fsm.sv
design/mbus_bridge_top.sv
bench/mbus_bridge_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP ?= mbus_bridge_tb
FILELIST ?= sources.f
BUILD_DIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --binary --timing --assert --timescale 1ns/100ps

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "ALL TESTS PASSED" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== bench/mbus_bridge_tb.sv ====
`timescale 1ns/100ps
`include "mbus_bridge_consts.svh"

module mbus_bridge_tb;

	import mbus_bridge_pkg::*;

	localparam int NUM_ENTRIES = 7;
	localparam int CYCLE_LIMIT = 400 * NUM_ENTRIES;
	localparam logic [1:0] KIND_RX = 2'd0;
	localparam logic [1:0] KIND_RX_FAIL = 2'd1;
	localparam logic [1:0] KIND_TX = 2'd2;

	typedef struct packed {
		logic [1:0]            kind;
		logic [3:0]            words;
		logic                  fail;
		logic                  bcast;
		logic [7:0]            code;
		logic [`CLK_DIV_W-1:0] div;
	} entry_t;

	logic                  clk;
	logic                  reset;
	logic [`CLK_DIV_W-1:0] clk_div;
	logic                  mbus_clk;
	logic [`TAG_W-1:0]     global_tag;
	mbus_rx_t              rx_word;
	logic                  rx_req;
	logic                  rx_ack;
	host_byte_t            out_byte;
	logic                  out_valid;
	logic                  incr_ctr;
	host_byte_t            in_byte;
	logic                  in_valid;
	logic                  in_next;
	mbus_tx_t              tx_word;
	logic                  tx_req;
	logic                  tx_ack;
	logic                  tx_succ;
	logic                  tx_fail;
	host_byte_t            msg_byte;
	logic                  msg_valid;

	entry_t     stim [NUM_ENTRIES];
	host_byte_t out_q[$];
	int         out_cyc_q[$];
	host_byte_t msg_q[$];
	host_byte_t host_frame_q[$];
	mbus_tx_t   tx_exp_q[$];
	int         cycle = 0;
	int         incr_count = 0;
	int         incr_cyc = 0;
	int         error_count = 0;

	mbus_bridge_top uut (
		.clk        (clk),
		.reset      (reset),
		.clk_div    (clk_div),
		.mbus_clk   (mbus_clk),
		.global_tag (global_tag),
		.rx_word    (rx_word),
		.rx_req     (rx_req),
		.rx_ack     (rx_ack),
		.out_byte   (out_byte),
		.out_valid  (out_valid),
		.incr_ctr   (incr_ctr),
		.in_byte    (in_byte),
		.in_valid   (in_valid),
		.in_next    (in_next),
		.tx_word    (tx_word),
		.tx_req     (tx_req),
		.tx_ack     (tx_ack),
		.tx_succ    (tx_succ),
		.tx_fail    (tx_fail),
		.msg_byte   (msg_byte),
		.msg_valid  (msg_valid)
	);

	always #10 clk = ~clk;

	task automatic abort_run();
		error_count++;
		$display("SOME TESTS FAILED");
		$fatal(1, "Simulation stopped at the first error");
	endtask

	task automatic value_error(input string what);
		$display("Fail at time %0t: %s", $time, what);
		abort_run();
	endtask

	// Watchdog
	always @(posedge clk) begin
		cycle = cycle + 1;
		if (cycle >= CYCLE_LIMIT) begin
			$display("Timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
			abort_run();
		end
	end

	// Output streams are sampled mid-cycle
	always @(negedge clk) begin
		if (!reset && out_valid) begin
			out_q.push_back(out_byte);
			out_cyc_q.push_back(cycle);
		end
		if (!reset && incr_ctr) begin
			incr_count++;
			incr_cyc = cycle;
		end
		if (!reset && msg_valid)
			msg_q.push_back(msg_byte);
	end

	function automatic host_byte_t mk_byte(input logic [7:0] data, input logic last);
		host_byte_t b;
		b.data = data;
		b.last = last;
		return b;
	endfunction

	function automatic entry_t make_entry(input logic [1:0] kind, input logic [3:0] words,
			input logic fail, input logic bcast, input logic [7:0] code,
			input logic [`CLK_DIV_W-1:0] div);
		entry_t e;
		e.kind = kind;
		e.words = words;
		e.fail = fail;
		e.bcast = bcast;
		e.code = code;
		e.div = div;
		return e;
	endfunction

	task automatic run_rx(input entry_t e);
		host_byte_t exp_q[$];
		mbus_rx_t   words[$];
		mbus_rx_t   w;
		logic       fail_or;
		logic       bcast_or;
		logic [7:0] status;
		int         n;
		fail_or = 1'b0;
		bcast_or = 1'b0;
		n = int'(e.words);
		global_tag = 8'($urandom());
		exp_q.push_back(mk_byte(`BRIDGE_FLAG, 1'b0));
		exp_q.push_back(mk_byte(global_tag, 1'b0));
		for (int k = 0; k < n; k++) begin
			w.addr = $urandom();
			w.data = $urandom();
			w.pend = (k < n - 1);
			// Fail on the second word if there is one, bcast on the last
			w.fail = e.fail && (k == ((n > 1) ? 1 : 0));
			w.bcast = e.bcast && (k == n - 1);
			fail_or = fail_or | w.fail;
			bcast_or = bcast_or | w.bcast;
			words.push_back(w);
			for (int j = 0; j < 4 && k == 0; j++)
				exp_q.push_back(mk_byte(8'(w.addr >> (8 * (3 - j))), 1'b0));
			for (int j = 0; j < 4; j++)
				exp_q.push_back(mk_byte(8'(w.data >> (8 * (3 - j))), 1'b0));
		end
		// Fail summary in bit 3, bcast summary in bit 2
		status = 8'h00;
		status[3] = fail_or;
		status[2] = bcast_or;
		exp_q.push_back(mk_byte(status, 1'b1));
		// Layer side, one word per request
		for (int k = 0; k < n; k++) begin
			@(posedge clk);
			#1;
			rx_word = words[k];
			rx_req = 1'b1;
			@(negedge clk);
			while (!rx_ack)
				@(negedge clk);
			@(posedge clk);
			#1;
			rx_req = 1'b0;
			rx_word = '0;
			repeat (2) @(posedge clk);
		end
		while (out_q.size() < exp_q.size())
			@(negedge clk);
		repeat (4) @(negedge clk);
		assert (out_q.size() == exp_q.size()) else
			value_error($sformatf("frame has %0d bytes, expected %0d",
				out_q.size(), exp_q.size()));
		for (int i = 0; i < exp_q.size(); i++) begin
			assert (out_q[i] == exp_q[i]) else
				value_error($sformatf("frame byte %0d is %h last %b, expected %h last %b",
					i, out_q[i].data, out_q[i].last, exp_q[i].data, exp_q[i].last));
		end
		assert (incr_count == 1) else
			value_error($sformatf("incr_ctr pulsed %0d times", incr_count));
		assert (incr_cyc == out_cyc_q[1] + 1) else
			value_error("incr_ctr not in the cycle after the tag byte");
	endtask

	task automatic run_rx_fail();
		int acks;
		acks = 0;
		@(posedge clk);
		#1;
		rx_word = '0;
		rx_word.fail = 1'b1;
		@(negedge clk);
		while (!rx_ack)
			@(negedge clk);
		while (rx_ack) begin
			acks++;
			@(negedge clk);
		end
		@(posedge clk);
		#1;
		rx_word = '0;
		repeat (8) @(negedge clk);
		assert (acks == 3) else
			value_error($sformatf("rx_ack high for %0d cycles on a fail, expected 3", acks));
		assert (out_q.size() == 0 && incr_count == 0) else
			value_error("a fail without request produced output");
	endtask

	// Host input, one byte per in_next
	task automatic feed_host();
		@(posedge clk);
		#1;
		in_byte = host_frame_q[0];
		in_valid = 1'b1;
		for (int i = 0; i < host_frame_q.size(); i++) begin
			@(negedge clk);
			while (!in_next)
				@(negedge clk);
			@(posedge clk);
			#1;
			if (i + 1 < host_frame_q.size()) begin
				in_byte = host_frame_q[i + 1];
			end else begin
				in_valid = 1'b0;
				in_byte = '0;
			end
		end
	endtask

	// Layer TX side with a slow tx_ack
	task automatic answer_tx(input logic nak);
		mbus_tx_t held;
		int       delay;
		for (int k = 0; k < tx_exp_q.size(); k++) begin
			@(negedge clk);
			while (!tx_req)
				@(negedge clk);
			held = tx_word;
			assert (held == tx_exp_q[k]) else
				value_error($sformatf("tx word %0d is %h, expected %h", k, held, tx_exp_q[k]));
			delay = 2 + int'($urandom() % 6);
			repeat (delay) begin
				@(negedge clk);
				assert (tx_word == held && tx_req) else
					value_error("tx_word or tx_req changed before tx_ack");
				assert (!in_next) else
					value_error("a host byte was pulled while tx_req was pending");
			end
			@(posedge clk);
			#1;
			tx_ack = 1'b1;
			@(posedge clk);
			#1;
			tx_ack = 1'b0;
		end
		if (nak)
			tx_fail = 1'b1;
		else
			tx_succ = 1'b1;
		@(posedge clk);
		#1;
		tx_fail = 1'b0;
		tx_succ = 1'b0;
	endtask

	task automatic run_tx(input entry_t e);
		mbus_tx_t    w;
		logic [7:0]  eid;
		logic [31:0] addr;
		int          n;
		n = int'(e.words);
		eid = 8'($urandom());
		addr = $urandom();
		host_frame_q.delete();
		tx_exp_q.delete();
		host_frame_q.push_back(mk_byte(eid, 1'b0));
		for (int j = 0; j < 4; j++)
			host_frame_q.push_back(mk_byte(8'(addr >> (8 * (3 - j))), 1'b0));
		for (int k = 0; k < n; k++) begin
			w.addr = addr;
			w.data = $urandom();
			w.pend = (k < n - 1);
			tx_exp_q.push_back(w);
			for (int j = 0; j < 4; j++)
				host_frame_q.push_back(mk_byte(8'(w.data >> (8 * (3 - j))),
					(k == n - 1) && (j == 3)));
		end
		fork
			feed_host();
			answer_tx(e.fail);
		join
		while (msg_q.size() < 2)
			@(negedge clk);
		repeat (3) @(negedge clk);
		assert (msg_q.size() == 2) else
			value_error($sformatf("completion has %0d bytes, expected 2", msg_q.size()));
		assert (msg_q[0] == mk_byte(e.code, 1'b0)) else
			value_error($sformatf("completion code %h, expected %h", msg_q[0].data, e.code));
		assert (msg_q[1] == mk_byte(eid, 1'b1)) else
			value_error($sformatf("completion id %h last %b, expected %h last 1",
				msg_q[1].data, msg_q[1].last, eid));
		assert (out_q.size() == 0) else
			value_error("a transmit produced receive bytes");
	endtask

	// Skip two toggles so a changed setting has settled
	task automatic check_divider(input logic [`CLK_DIV_W-1:0] div);
		int   gap;
		logic prev;
		for (int t = 0; t < 5; t++) begin
			gap = 0;
			prev = mbus_clk;
			do begin
				@(negedge clk);
				gap++;
			end while (mbus_clk == prev);
			if (t >= 2) begin
				assert (gap == int'(div) + 1) else
					value_error($sformatf("mbus_clk half period %0d cycles, expected %0d",
						gap, int'(div) + 1));
			end
		end
	endtask

	task automatic run_entry(input entry_t e);
		@(posedge clk);
		#1;
		clk_div = e.div;
		out_q.delete();
		out_cyc_q.delete();
		msg_q.delete();
		incr_count = 0;
		case (e.kind)
			KIND_RX: run_rx(e);
			KIND_RX_FAIL: run_rx_fail();
			default: run_tx(e);
		endcase
		check_divider(e.div);
	endtask

	initial begin
		int unsigned seed_ret;
		seed_ret = $urandom(32'hb8af_532f);
		clk = 1'b0;
		reset = 1'b1;
		clk_div = `CLK_DIV_W'(3);
		global_tag = '0;
		rx_word = '0;
		rx_req = 1'b0;
		in_byte = '0;
		in_valid = 1'b0;
		tx_ack = 1'b0;
		tx_succ = 1'b0;
		tx_fail = 1'b0;
		// kind, words, fail, bcast, completion code, divider
		stim[0] = make_entry(KIND_RX, 4'd1, 1'b0, 1'b0, 8'h00, `CLK_DIV_W'(3));
		stim[1] = make_entry(KIND_RX, 4'd3, 1'b1, 1'b1, 8'h00, `CLK_DIV_W'(3));
		stim[2] = make_entry(KIND_RX_FAIL, 4'd0, 1'b1, 1'b0, 8'h00, `CLK_DIV_W'(5));
		stim[3] = make_entry(KIND_TX, 4'd2, 1'b0, 1'b0, `ACK_CODE, `CLK_DIV_W'(5));
		stim[4] = make_entry(KIND_TX, 4'd2, 1'b1, 1'b0, `NAK_CODE, `CLK_DIV_W'(2));
		stim[5] = make_entry(KIND_RX, 4'd2, 1'b0, 1'b1, 8'h00, `CLK_DIV_W'(2));
		stim[6] = make_entry(KIND_TX, 4'd1, 1'b0, 1'b0, `ACK_CODE, `CLK_DIV_W'(4));
		repeat (3) @(posedge clk);
		#1;
		reset = 1'b0;
		@(negedge clk);
		assert (!rx_ack && !tx_req && !out_valid && !msg_valid && !in_next && !incr_ctr) else
			value_error("an output is high after reset");
		for (int i = 0; i < NUM_ENTRIES; i++)
			run_entry(stim[i]);
		if (error_count == 0) begin
			$display("ALL TESTS PASSED");
		end else begin
			$display("SOME TESTS FAILED");
		end
		$finish;
	end

endmodule

// ==== design/mbus_bridge_top.sv ====
`timescale 1ns/100ps
`include "mbus_bridge_consts.svh"

module mbus_bridge_top (
	input  logic                        clk,
	input  logic                        reset,
	input  logic [`CLK_DIV_W-1:0]       clk_div,
	output logic                        mbus_clk,
	input  logic [`TAG_W-1:0]           global_tag,
	input  mbus_bridge_pkg::mbus_rx_t   rx_word,
	input  logic                        rx_req,
	output logic                        rx_ack,
	output mbus_bridge_pkg::host_byte_t out_byte,
	output logic                        out_valid,
	output logic                        incr_ctr,
	input  mbus_bridge_pkg::host_byte_t in_byte,
	input  logic                        in_valid,
	output logic                        in_next,
	output mbus_bridge_pkg::mbus_tx_t   tx_word,
	output logic                        tx_req,
	input  logic                        tx_ack,
	input  logic                        tx_succ,
	input  logic                        tx_fail,
	output mbus_bridge_pkg::host_byte_t msg_byte,
	output logic                        msg_valid
);

	import mbus_bridge_pkg::*;

	ser_ctl_t   ser_ctl;
	asm_ctl_t   asm_ctl;
	logic [3:0] bytes_left;
	logic       saw_last;
	logic [7:0] eid;
	logic       send_ack;
	logic       send_nak;
	logic       ack_busy;

	mbus_clk_divider u_clk_div (
		.clk      (clk),
		.reset    (reset),
		.clk_div  (clk_div),
		.mbus_clk (mbus_clk)
	);

	// The fail level travels in the received word
	bridge_fsm u_fsm (
		.clk        (clk),
		.reset      (reset),
		.rx_req     (rx_req),
		.rx_fail    (rx_word.fail),
		.rx_ack     (rx_ack),
		.ser_ctl    (ser_ctl),
		.bytes_left (bytes_left),
		.pend_seen  (rx_word.pend),
		.incr_ctr   (incr_ctr),
		.in_valid   (in_valid),
		.in_next    (in_next),
		.asm_ctl    (asm_ctl),
		.saw_last   (saw_last),
		.tx_req     (tx_req),
		.tx_ack     (tx_ack),
		.tx_succ    (tx_succ),
		.tx_fail    (tx_fail),
		.send_ack   (send_ack),
		.send_nak   (send_nak),
		.ack_busy   (ack_busy)
	);

	rx_serializer u_ser (
		.clk        (clk),
		.reset      (reset),
		.ctl        (ser_ctl),
		.rx_word    (rx_word),
		.tag        (global_tag),
		.out_byte   (out_byte),
		.out_valid  (out_valid),
		.bytes_left (bytes_left)
	);

	tx_assembler u_asm (
		.clk      (clk),
		.reset    (reset),
		.ctl      (asm_ctl),
		.in_byte  (in_byte),
		.tx_word  (tx_word),
		.eid      (eid),
		.saw_last (saw_last)
	);

	ack_builder u_ack (
		.clk       (clk),
		.reset     (reset),
		.send_ack  (send_ack),
		.send_nak  (send_nak),
		.eid       (eid),
		.msg_byte  (msg_byte),
		.msg_valid (msg_valid),
		.busy      (ack_busy)
	);

endmodule

// ==== design/bridge_fsm.sv ====
`timescale 1ns/100ps

module bridge_fsm (
	input  logic                      clk,
	input  logic                      reset,
	input  logic                      rx_req,
	input  logic                      rx_fail,
	output logic                      rx_ack,
	output mbus_bridge_pkg::ser_ctl_t ser_ctl,
	input  logic [3:0]                bytes_left,
	input  logic                      pend_seen,
	output logic                      incr_ctr,
	input  logic                      in_valid,
	output logic                      in_next,
	output mbus_bridge_pkg::asm_ctl_t asm_ctl,
	input  logic                      saw_last,
	output logic                      tx_req,
	input  logic                      tx_ack,
	input  logic                      tx_succ,
	input  logic                      tx_fail,
	output logic                      send_ack,
	output logic                      send_nak,
	input  logic                      ack_busy
);

	typedef enum logic [3:0] {
		S_IDLE,
		S_FLAG,
		S_TAG,
		S_CAPTURE,
		S_DRAIN,
		S_CHECK_PEND,
		S_STATUS,
		S_FAIL_ACK,
		S_TX_EID,
		S_TX_ADDR,
		S_TX_DATA,
		S_TX_REQ,
		S_TX_WAIT,
		S_TX_END,
		S_TX_FIN
	} state_t;

	state_t     state;
	state_t     next_state;
	logic [1:0] req_sync;
	logic [1:0] fail_sync;
	logic       rx_req_s;
	logic       rx_fail_s;
	logic [2:0] cnt;
	logic       first_word;
	logic       pend_q;
	logic       tag_d;
	// Request must be seen low after each ack before it counts again
	logic       req_low;
	logic       fail_hold;

	assign rx_req_s = req_sync[1];
	assign rx_fail_s = fail_sync[1];

	always_comb begin
		next_state = state;
		ser_ctl = '0;
		asm_ctl = '0;
		in_next = 1'b0;
		send_ack = 1'b0;
		send_nak = 1'b0;
		case (state)
			S_IDLE: begin
				if (rx_req_s && req_low)
					next_state = S_FLAG;
				else if (rx_fail_s && !fail_hold)
					next_state = S_FAIL_ACK;
				else if (in_valid)
					next_state = S_TX_EID;
			end
			S_FLAG: begin
				ser_ctl.send_flag = 1'b1;
				next_state = S_TAG;
			end
			S_TAG: begin
				ser_ctl.send_tag = 1'b1;
				next_state = S_CAPTURE;
			end
			S_CAPTURE: begin
				ser_ctl.load_first = first_word;
				ser_ctl.load_next = ~first_word;
				next_state = S_DRAIN;
			end
			S_DRAIN: begin
				ser_ctl.shift = 1'b1;
				if (bytes_left == 4'd1)
					next_state = S_CHECK_PEND;
			end
			S_CHECK_PEND: begin
				if (!pend_q)
					next_state = S_STATUS;
				else if (rx_req_s && req_low)
					next_state = S_CAPTURE;
			end
			S_STATUS: begin
				ser_ctl.send_status = 1'b1;
				next_state = S_IDLE;
			end
			// Three cycles of rx_ack, no frame
			S_FAIL_ACK: begin
				if (cnt == 3'd2)
					next_state = S_IDLE;
			end
			S_TX_EID: begin
				if (in_valid) begin
					in_next = 1'b1;
					asm_ctl.take_eid = 1'b1;
					asm_ctl.clear = 1'b1;
					next_state = S_TX_ADDR;
				end
			end
			S_TX_ADDR: begin
				if (in_valid) begin
					in_next = 1'b1;
					asm_ctl.shift_addr = 1'b1;
					if (cnt == 3'd3)
						next_state = S_TX_DATA;
				end
			end
			S_TX_DATA: begin
				if (in_valid) begin
					in_next = 1'b1;
					asm_ctl.shift_data = 1'b1;
					if (cnt == 3'd3)
						next_state = S_TX_REQ;
				end
			end
			S_TX_REQ: begin
				next_state = S_TX_WAIT;
			end
			// No byte pulls while the layer holds off
			S_TX_WAIT: begin
				if (tx_ack)
					next_state = saw_last ? S_TX_END : S_TX_DATA;
			end
			S_TX_END: begin
				if (tx_fail) begin
					send_nak = 1'b1;
					next_state = S_TX_FIN;
				end else if (tx_succ) begin
					send_ack = 1'b1;
					next_state = S_TX_FIN;
				end
			end
			S_TX_FIN: begin
				if (!ack_busy)
					next_state = S_IDLE;
			end
			default: begin
				next_state = S_IDLE;
			end
		endcase
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= S_IDLE;
			req_sync <= 2'b00;
			fail_sync <= 2'b00;
			rx_ack <= 1'b0;
			tx_req <= 1'b0;
			tag_d <= 1'b0;
			incr_ctr <= 1'b0;
			cnt <= 3'd0;
			first_word <= 1'b1;
			pend_q <= 1'b0;
			req_low <= 1'b1;
			fail_hold <= 1'b0;
		end else begin
			state <= next_state;
			req_sync <= {req_sync[0], rx_req};
			fail_sync <= {fail_sync[0], rx_fail};
			rx_ack <= (state == S_CAPTURE) || (state == S_FAIL_ACK);
			// Counter pulse lands one cycle after the tag byte
			tag_d <= (state == S_TAG);
			incr_ctr <= tag_d;
			if (state != next_state)
				cnt <= 3'd0;
			else if (in_next || state == S_FAIL_ACK)
				cnt <= cnt + 3'd1;
			if (state == S_IDLE)
				first_word <= 1'b1;
			else if (state == S_CAPTURE)
				first_word <= 1'b0;
			if (state == S_CAPTURE)
				pend_q <= pend_seen;
			if (state == S_CAPTURE)
				req_low <= 1'b0;
			else if (!rx_req_s)
				req_low <= 1'b1;
			if (state == S_CAPTURE || state == S_FAIL_ACK)
				fail_hold <= 1'b1;
			else if (!rx_fail_s)
				fail_hold <= 1'b0;
			if (state == S_TX_REQ)
				tx_req <= 1'b1;
			else if (state == S_TX_WAIT && tx_ack)
				tx_req <= 1'b0;
		end
	end

endmodule

// ==== design/ack_builder.sv ====
`timescale 1ns/100ps
`include "mbus_bridge_consts.svh"

module ack_builder (
	input  logic                        clk,
	input  logic                        reset,
	input  logic                        send_ack,
	input  logic                        send_nak,
	input  logic [7:0]                  eid,
	output mbus_bridge_pkg::host_byte_t msg_byte,
	output logic                        msg_valid,
	output logic                        busy
);

	// High while the code byte is out and the id is still owed
	logic eid_due;

	always_ff @(posedge clk) begin
		if (reset) begin
			msg_valid <= 1'b0;
			eid_due <= 1'b0;
		end else begin
			msg_valid <= send_ack | send_nak | eid_due;
			eid_due <= send_ack | send_nak;
		end
	end

	// NAK wins if both are requested
	always_ff @(posedge clk) begin
		if (send_nak)
			msg_byte <= {`NAK_CODE, 1'b0};
		else if (send_ack)
			msg_byte <= {`ACK_CODE, 1'b0};
		else if (eid_due)
			msg_byte <= {eid, 1'b1};
	end

	assign busy = msg_valid;

endmodule

// ==== design/tx_assembler.sv ====
`timescale 1ns/100ps

module tx_assembler (
	input  logic                        clk,
	input  logic                        reset,
	input  mbus_bridge_pkg::asm_ctl_t   ctl,
	input  mbus_bridge_pkg::host_byte_t in_byte,
	output mbus_bridge_pkg::mbus_tx_t   tx_word,
	output logic [7:0]                  eid,
	output logic                        saw_last
);

	logic [31:0] addr_sr;
	logic [31:0] data_sr;

	// Bytes enter at the bottom, MSB first
	always_ff @(posedge clk) begin
		if (ctl.take_eid)
			eid <= in_byte.data;
		if (ctl.shift_addr)
			addr_sr <= {addr_sr[23:0], in_byte.data};
		if (ctl.shift_data)
			data_sr <= {data_sr[23:0], in_byte.data};
	end

	// Sticky until the next frame starts
	always_ff @(posedge clk) begin
		if (reset)
			saw_last <= 1'b0;
		else if (ctl.clear)
			saw_last <= 1'b0;
		else if (ctl.shift_data && in_byte.last)
			saw_last <= 1'b1;
	end

	assign tx_word.addr = addr_sr;
	assign tx_word.data = data_sr;
	// Final word of the frame goes out without pend
	assign tx_word.pend = ~saw_last;

endmodule

// ==== design/rx_serializer.sv ====
`timescale 1ns/100ps
`include "mbus_bridge_consts.svh"

module rx_serializer (
	input  logic                        clk,
	input  logic                        reset,
	input  mbus_bridge_pkg::ser_ctl_t   ctl,
	input  mbus_bridge_pkg::mbus_rx_t   rx_word,
	input  logic [`TAG_W-1:0]           tag,
	output mbus_bridge_pkg::host_byte_t out_byte,
	output logic                        out_valid,
	output logic [3:0]                  bytes_left
);

	logic [63:0] shift_reg;
	logic        fail_acc;
	logic        bcast_acc;
	logic [7:0]  next_data;

	// Fixed bytes take priority over the shift register
	always_comb begin
		if (ctl.send_flag)
			next_data = `BRIDGE_FLAG;
		else if (ctl.send_tag)
			next_data = tag;
		else if (ctl.send_status)
			next_data = {4'b0000, fail_acc, bcast_acc, 2'b00};
		else
			next_data = shift_reg[63:56];
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			out_valid <= 1'b0;
			bytes_left <= 4'd0;
			fail_acc <= 1'b0;
			bcast_acc <= 1'b0;
		end else begin
			out_valid <= ctl.shift | ctl.send_flag | ctl.send_tag | ctl.send_status;
			if (ctl.load_first) begin
				bytes_left <= 4'd8;
				fail_acc <= rx_word.fail;
				bcast_acc <= rx_word.bcast;
			end else if (ctl.load_next) begin
				bytes_left <= 4'd4;
				fail_acc <= fail_acc | rx_word.fail;
				bcast_acc <= bcast_acc | rx_word.bcast;
			end else if (ctl.shift) begin
				bytes_left <= bytes_left - 4'd1;
			end
		end
	end

	// Later words carry data only, so it goes to the top half
	always_ff @(posedge clk) begin
		if (ctl.load_first)
			shift_reg <= {rx_word.addr, rx_word.data};
		else if (ctl.load_next)
			shift_reg <= {rx_word.data, 32'h0000_0000};
		else if (ctl.shift)
			shift_reg <= {shift_reg[55:0], 8'h00};
		out_byte.data <= next_data;
		out_byte.last <= ctl.send_status;
	end

endmodule

// ==== design/mbus_clk_divider.sv ====
`timescale 1ns/100ps
`include "mbus_bridge_consts.svh"

module mbus_clk_divider (
	input  logic                  clk,
	input  logic                  reset,
	input  logic [`CLK_DIV_W-1:0] clk_div,
	output logic                  mbus_clk
);

	logic [`CLK_DIV_W-1:0] count;

	// Compare with >= so a lowered setting still wraps promptly
	always_ff @(posedge clk) begin
		if (reset) begin
			count <= '0;
			mbus_clk <= 1'b0;
		end else if (count >= clk_div) begin
			count <= '0;
			mbus_clk <= ~mbus_clk;
		end else begin
			count <= count + 1'b1;
		end
	end

endmodule

// ==== design/mbus_bridge_pkg.sv ====
package mbus_bridge_pkg;

	// One byte on a host stream
	typedef struct packed {
		logic [7:0] data;
		logic       last;
	} host_byte_t;

	// Word as presented by the layer controller
	typedef struct packed {
		logic [31:0] addr;
		logic [31:0] data;
		logic        pend;
		logic        fail;
		logic        bcast;
	} mbus_rx_t;

	// Word handed to the layer for transmit
	typedef struct packed {
		logic [31:0] addr;
		logic [31:0] data;
		logic        pend;
	} mbus_tx_t;

	// Serializer command, at most one bit set per cycle
	typedef struct packed {
		logic load_first;
		logic load_next;
		logic shift;
		logic send_flag;
		logic send_tag;
		logic send_status;
	} ser_ctl_t;

	// Assembler command
	typedef struct packed {
		logic take_eid;
		logic shift_addr;
		logic shift_data;
		logic clear;
	} asm_ctl_t;

endpackage

// ==== design/mbus_bridge_consts.svh ====
`ifndef MBUS_BRIDGE_CONSTS_SVH
`define MBUS_BRIDGE_CONSTS_SVH

// Leading byte of every receive frame
`define BRIDGE_FLAG 8'h42

// Completion message codes
`define ACK_CODE 8'h06
`define NAK_CODE 8'h15

// Width of the MBus clock divider setting
`define CLK_DIV_W 22

// Width of the global time tag
`define TAG_W 8

`endif
